/* common/dcache_ctrl_pkg.sv */
// ----------------------------------------
// Data cache controller types
// FSM states and way numbers
// ----------------------------------------
`include "dcache_defines.svh"

package dcache_ctrl_pkg;

    // Controller FSM
    typedef enum logic [3:0]
    {
        INIT,
        LOOKUP,
        EVICT,
        EVICT_WAIT,
        REFILL,
        FINISH_READ,
        FINISH_WRITE
    } ctrl_state_e;

    // Way number, used for the victim and the hitting way
    typedef logic [$clog2(`DC_NUM_WAYS)-1:0] way_sel_t;

endpackage

/* common/dcache_defines.svh */
// ----------------------------------------
// Data cache geometry
// Widths and address field positions
// ----------------------------------------
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Bus widths
`define DC_ADDR_W       32
`define DC_DATA_W       32
`define DC_STRB_W       4

// Organisation, 2 ways of 16 sets of 16-byte lines
`define DC_NUM_WAYS     2
`define DC_SET_W        4
`define DC_OFFS_W       4
`define DC_LINE_WORDS   4
`define DC_TAG_W        (`DC_ADDR_W - `DC_SET_W - `DC_OFFS_W)

// Address field positions
`define DC_WORD_LSB     2
`define DC_SET_LSB      `DC_OFFS_W
`define DC_TAG_LSB      (`DC_OFFS_W + `DC_SET_W)

`endif

/* common/dcache_mem_pkg.sv */
// ----------------------------------------
// Data cache memory types
// Words, strobes and address fields
// ----------------------------------------
`include "dcache_defines.svh"

package dcache_mem_pkg;

    // One data word on either port
    typedef logic [`DC_DATA_W-1:0] word_t;

    // Byte write enables
    typedef logic [`DC_STRB_W-1:0] strb_t;

    // Byte address
    typedef logic [`DC_ADDR_W-1:0] addr_t;

    // Stored tag, upper address bits
    typedef logic [`DC_TAG_W-1:0] tag_t;

    // Set index
    typedef logic [`DC_SET_W-1:0] set_t;

    // Word within a line
    typedef logic [`DC_OFFS_W-`DC_WORD_LSB-1:0] word_idx_t;

endpackage

/* dcache.f */
+incdir+common
common/dcache_mem_pkg.sv
common/dcache_ctrl_pkg.sv
hw/dcache/dcache_way.sv
hw/dcache/dcache_ctrl.sv
hw/dcache/dcache_top.sv
verification/dcache_props.sv
verification/dcache_tb.sv

/* hw/dcache/dcache_ctrl.sv */
// ----------------------------------------
// Data cache controller
// Request buffer, miss FSM, replacement
// and line burst sequencing
// ----------------------------------------
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl
(
    input  logic                           clk,
    input  logic                           rst_n,
    // CPU port
    input  dcache_mem_pkg::addr_t          addr_i,
    input  dcache_mem_pkg::word_t          wdata_i,
    input  logic                           rd_i,
    input  dcache_mem_pkg::strb_t          strb_i,
    output logic                           accept_o,
    output logic                           ack_o,
    output dcache_mem_pkg::word_t          rdata_o,
    // Memory port
    output logic                           mem_rd_o,
    output logic                           mem_wr_o,
    output dcache_mem_pkg::addr_t          mem_addr_o,
    output dcache_mem_pkg::word_t          mem_wdata_o,
    input  logic                           mem_accept_i,
    input  logic                           mem_ack_i,
    input  dcache_mem_pkg::word_t          mem_rdata_i,
    // Way control
    output dcache_mem_pkg::set_t           look_set_o,
    output dcache_mem_pkg::tag_t           cmp_tag_o,
    output dcache_mem_pkg::set_t           fill_set_o,
    output dcache_mem_pkg::word_idx_t      fill_word_o,
    output dcache_mem_pkg::word_t          wr_data_o,
    output dcache_mem_pkg::tag_t           new_tag_o,
    output logic [`DC_NUM_WAYS-1:0]        tag_we_o,
    output logic [`DC_NUM_WAYS-1:0]        tag_valid_o,
    output logic [`DC_NUM_WAYS-1:0]        tag_dirty_o,
    output dcache_mem_pkg::strb_t          data_strb_o [`DC_NUM_WAYS],
    // Way results
    input  logic [`DC_NUM_WAYS-1:0]        way_hit_i,
    input  logic [`DC_NUM_WAYS-1:0]        way_dirty_i,
    input  dcache_mem_pkg::tag_t           way_tag_i [`DC_NUM_WAYS],
    input  dcache_mem_pkg::word_t          way_rdata_i [`DC_NUM_WAYS]
);
    import dcache_mem_pkg::*;
    import dcache_ctrl_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // Buffered request
    logic      req_q;
    addr_t     addr_q;
    word_t     wdata_q;
    strb_t     strb_q;

    set_t      init_cnt_q;
    way_sel_t  repl_q;
    word_idx_t word_cnt_q;
    logic      rd_sent_q;

    set_t      req_set;
    tag_t      req_tag;
    word_idx_t req_word;
    way_sel_t  hit_way;
    logic      hit_any;
    logic      is_write;
    logic      miss;
    logic      hold_raw;
    logic      new_req;
    logic      last_word;

    assign req_set  = addr_q[`DC_SET_LSB +: `DC_SET_W];
    assign req_tag  = addr_q[`DC_TAG_LSB +: `DC_TAG_W];
    assign req_word = addr_q[`DC_WORD_LSB +: (`DC_OFFS_W - `DC_WORD_LSB)];

    // ----------------------------------------
    // Way combining
    // ----------------------------------------
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `DC_NUM_WAYS; w++)
        begin
            if (way_hit_i[w])
                hit_way = way_sel_t'(w);
        end
    end

    assign hit_any   = |way_hit_i;
    assign is_write  = |strb_q;
    assign miss      = req_q && !hit_any;
    assign last_word = (word_cnt_q == word_idx_t'(`DC_LINE_WORDS - 1));

    // ----------------------------------------
    // CPU handshake
    // ----------------------------------------
    // Read of the word being written this cycle waits one cycle
    assign hold_raw = req_q && is_write && rd_i &&
                      (addr_i[`DC_ADDR_W-1:`DC_WORD_LSB] == addr_q[`DC_ADDR_W-1:`DC_WORD_LSB]);

    assign accept_o = (state_q == LOOKUP) && !miss && !hold_raw;
    assign new_req  = accept_o && (rd_i || (|strb_i));

    assign ack_o = ((state_q == LOOKUP) && req_q && hit_any) ||
                   (state_q == FINISH_READ) || (state_q == FINISH_WRITE);
    assign rdata_o = way_rdata_i[hit_way];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            req_q <= 1'b0;
        else if (new_req)
            req_q <= 1'b1;
        else if (ack_o)
            req_q <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (new_req)
        begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            strb_q  <= strb_i;
        end
    end

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            INIT:
                if (init_cnt_q == '1)
                    state_d = LOOKUP;
            LOOKUP:
                if (miss)
                    state_d = way_dirty_i[repl_q] ? EVICT : REFILL;
            EVICT:
                if (mem_accept_i && last_word)
                    state_d = EVICT_WAIT;
            EVICT_WAIT:
                if (mem_ack_i)
                    state_d = REFILL;
            REFILL:
                if (mem_ack_i && last_word)
                    state_d = is_write ? FINISH_WRITE : FINISH_READ;
            FINISH_READ, FINISH_WRITE:
                state_d = LOOKUP;
            default:
                state_d = INIT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q    <= INIT;
            init_cnt_q <= '0;
            repl_q     <= '0;
            word_cnt_q <= '0;
            rd_sent_q  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == INIT)
                init_cnt_q <= init_cnt_q + 1'b1;
            // Alternate victim after each completed miss
            if (state_q == FINISH_READ || state_q == FINISH_WRITE)
                repl_q <= repl_q + 1'b1;
            // Wraps back to zero at the end of every burst
            if ((state_q == EVICT && mem_accept_i) || (state_q == REFILL && mem_ack_i))
                word_cnt_q <= word_cnt_q + 1'b1;
            if (state_q != REFILL)
                rd_sent_q <= 1'b0;
            else if (mem_rd_o && mem_accept_i)
                rd_sent_q <= 1'b1;
        end
    end

    // ----------------------------------------
    // Way control
    // ----------------------------------------
    always_comb
    begin
        // Keep the buffered set registered while a miss is handled
        look_set_o  = (state_q == LOOKUP && !miss) ? addr_i[`DC_SET_LSB +: `DC_SET_W] : req_set;
        cmp_tag_o   = req_tag;
        fill_set_o  = (state_q == INIT) ? init_cnt_q : req_set;
        fill_word_o = (state_q == EVICT || state_q == REFILL) ? word_cnt_q : req_word;
        wr_data_o   = (state_q == REFILL) ? mem_rdata_i : wdata_q;
        new_tag_o   = req_tag;
        for (int w = 0; w < `DC_NUM_WAYS; w++)
        begin
            tag_we_o[w]    = 1'b0;
            tag_valid_o[w] = 1'b1;
            tag_dirty_o[w] = 1'b0;
            data_strb_o[w] = '0;
            case (state_q)
                INIT:
                begin
                    tag_we_o[w]    = 1'b1;
                    tag_valid_o[w] = 1'b0;
                end
                LOOKUP:
                    if (req_q && is_write && way_hit_i[w])
                    begin
                        tag_we_o[w]    = 1'b1;
                        tag_dirty_o[w] = 1'b1;
                        data_strb_o[w] = strb_q;
                    end
                REFILL:
                    if (repl_q == way_sel_t'(w) && mem_ack_i)
                    begin
                        // Tag goes valid with the last word
                        tag_we_o[w]    = last_word;
                        data_strb_o[w] = '1;
                    end
                FINISH_WRITE:
                    if (repl_q == way_sel_t'(w))
                    begin
                        tag_we_o[w]    = 1'b1;
                        tag_dirty_o[w] = 1'b1;
                        data_strb_o[w] = strb_q;
                    end
                default:
                    ;
            endcase
        end
    end

    // ----------------------------------------
    // Memory port
    // ----------------------------------------
    assign mem_wr_o    = (state_q == EVICT);
    assign mem_rd_o    = (state_q == REFILL) && !rd_sent_q;
    assign mem_wdata_o = way_rdata_i[repl_q];
    assign mem_addr_o  = (state_q == EVICT) ?
                         {way_tag_i[repl_q], req_set, word_cnt_q, {`DC_WORD_LSB{1'b0}}} :
                         {addr_q[`DC_ADDR_W-1:`DC_OFFS_W], {`DC_OFFS_W{1'b0}}};

endmodule

/* hw/dcache/dcache_top.sv */
// ----------------------------------------
// Data cache top level
// Controller and two ways
// ----------------------------------------
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top
(
    input  logic                  clk,
    input  logic                  rst_n,
    // CPU port
    input  dcache_mem_pkg::addr_t addr_i,
    input  dcache_mem_pkg::word_t wdata_i,
    input  logic                  rd_i,
    input  dcache_mem_pkg::strb_t strb_i,
    output logic                  accept_o,
    output logic                  ack_o,
    output dcache_mem_pkg::word_t rdata_o,
    // Memory port
    output logic                  mem_rd_o,
    output logic                  mem_wr_o,
    output dcache_mem_pkg::addr_t mem_addr_o,
    output dcache_mem_pkg::word_t mem_wdata_o,
    input  logic                  mem_accept_i,
    input  logic                  mem_ack_i,
    input  dcache_mem_pkg::word_t mem_rdata_i
);
    // Shared way control
    dcache_mem_pkg::set_t      look_set;
    dcache_mem_pkg::tag_t      cmp_tag;
    dcache_mem_pkg::set_t      fill_set;
    dcache_mem_pkg::word_idx_t fill_word;
    dcache_mem_pkg::word_t     wr_data;
    dcache_mem_pkg::tag_t      new_tag;

    // Per-way control and results
    logic [`DC_NUM_WAYS-1:0]   tag_we;
    logic [`DC_NUM_WAYS-1:0]   tag_valid;
    logic [`DC_NUM_WAYS-1:0]   tag_dirty;
    dcache_mem_pkg::strb_t     data_strb [`DC_NUM_WAYS];
    logic [`DC_NUM_WAYS-1:0]   way_hit;
    logic [`DC_NUM_WAYS-1:0]   way_dirty;
    dcache_mem_pkg::tag_t      way_tag [`DC_NUM_WAYS];
    dcache_mem_pkg::word_t     way_rdata [`DC_NUM_WAYS];

    dcache_ctrl u_ctrl
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .rd_i         (rd_i),
        .strb_i       (strb_i),
        .accept_o     (accept_o),
        .ack_o        (ack_o),
        .rdata_o      (rdata_o),
        .mem_rd_o     (mem_rd_o),
        .mem_wr_o     (mem_wr_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_accept_i (mem_accept_i),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i),
        .look_set_o   (look_set),
        .cmp_tag_o    (cmp_tag),
        .fill_set_o   (fill_set),
        .fill_word_o  (fill_word),
        .wr_data_o    (wr_data),
        .new_tag_o    (new_tag),
        .tag_we_o     (tag_we),
        .tag_valid_o  (tag_valid),
        .tag_dirty_o  (tag_dirty),
        .data_strb_o  (data_strb),
        .way_hit_i    (way_hit),
        .way_dirty_i  (way_dirty),
        .way_tag_i    (way_tag),
        .way_rdata_i  (way_rdata)
    );

    dcache_way u_way0
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .look_set_i   (look_set),
        .cmp_tag_i    (cmp_tag),
        .fill_set_i   (fill_set),
        .fill_word_i  (fill_word),
        .tag_we_i     (tag_we[0]),
        .tag_valid_i  (tag_valid[0]),
        .tag_dirty_i  (tag_dirty[0]),
        .new_tag_i    (new_tag),
        .data_strb_i  (data_strb[0]),
        .wr_data_i    (wr_data),
        .hit_o        (way_hit[0]),
        .dirty_o      (way_dirty[0]),
        .tag_o        (way_tag[0]),
        .rdata_o      (way_rdata[0])
    );

    dcache_way u_way1
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .look_set_i   (look_set),
        .cmp_tag_i    (cmp_tag),
        .fill_set_i   (fill_set),
        .fill_word_i  (fill_word),
        .tag_we_i     (tag_we[1]),
        .tag_valid_i  (tag_valid[1]),
        .tag_dirty_i  (tag_dirty[1]),
        .new_tag_i    (new_tag),
        .data_strb_i  (data_strb[1]),
        .wr_data_i    (wr_data),
        .hit_o        (way_hit[1]),
        .dirty_o      (way_dirty[1]),
        .tag_o        (way_tag[1]),
        .rdata_o      (way_rdata[1])
    );

endmodule

/* hw/dcache/dcache_way.sv */
// ----------------------------------------
// Data cache way
// Tag, state bits and line data of one way
// Registered lookup with hit and dirty
// ----------------------------------------
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_way
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  dcache_mem_pkg::set_t      look_set_i,
    input  dcache_mem_pkg::tag_t      cmp_tag_i,
    input  dcache_mem_pkg::set_t      fill_set_i,
    input  dcache_mem_pkg::word_idx_t fill_word_i,
    input  logic                      tag_we_i,
    input  logic                      tag_valid_i,
    input  logic                      tag_dirty_i,
    input  dcache_mem_pkg::tag_t      new_tag_i,
    input  dcache_mem_pkg::strb_t     data_strb_i,
    input  dcache_mem_pkg::word_t     wr_data_i,
    output logic                      hit_o,
    output logic                      dirty_o,
    output dcache_mem_pkg::tag_t      tag_o,
    output dcache_mem_pkg::word_t     rdata_o
);
    import dcache_mem_pkg::*;

    localparam int SETS = 1 << `DC_SET_W;

    typedef word_t [`DC_LINE_WORDS-1:0] line_t;

    // Storage, cleared by the controller's INIT sweep
    tag_t  tag_mem   [SETS];
    logic  valid_mem [SETS];
    logic  dirty_mem [SETS];
    line_t data_mem  [SETS];

    tag_t  rd_tag;
    logic  rd_valid;
    logic  rd_dirty;
    line_t rd_line;

    tag_t  tag_q;
    logic  valid_q;
    logic  dirty_q;
    line_t line_q;

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (tag_we_i)
        begin
            tag_mem[fill_set_i]   <= new_tag_i;
            valid_mem[fill_set_i] <= tag_valid_i;
            dirty_mem[fill_set_i] <= tag_dirty_i;
        end
        for (int b = 0; b < `DC_STRB_W; b++)
        begin
            if (data_strb_i[b])
                data_mem[fill_set_i][fill_word_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------
    // A write landing on the looked-up set at the same edge is forwarded,
    // so back-to-back requests see the latest dirty bit and bytes
    always_comb
    begin
        rd_tag   = tag_mem[look_set_i];
        rd_valid = valid_mem[look_set_i];
        rd_dirty = dirty_mem[look_set_i];
        rd_line  = data_mem[look_set_i];
        if (fill_set_i == look_set_i)
        begin
            if (tag_we_i)
            begin
                rd_tag   = new_tag_i;
                rd_valid = tag_valid_i;
                rd_dirty = tag_dirty_i;
            end
            for (int b = 0; b < `DC_STRB_W; b++)
            begin
                if (data_strb_i[b])
                    rd_line[fill_word_i][b*8 +: 8] = wr_data_i[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end
        else
        begin
            valid_q <= rd_valid;
            dirty_q <= rd_dirty;
        end
    end

    always_ff @(posedge clk)
    begin
        tag_q  <= rd_tag;
        line_q <= rd_line;
    end

    // Compare against the buffered request's tag
    assign hit_o   = valid_q && (tag_q == cmp_tag_i);
    assign dirty_o = valid_q && dirty_q;
    assign tag_o   = tag_q;
    assign rdata_o = line_q[fill_word_i];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the data cache simulation with Verilator
# The exit status is the verdict of the run
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f dcache.f -o dcache_sim &&
./obj_dir/dcache_sim ||
{ echo "dcache simulation did not pass"; exit 1; }

/* verification/dcache_props.sv */
// ----------------------------------------
// Data cache protocol properties
// CPU and memory handshake assertions
// ----------------------------------------
`timescale 1ns/1ps

module dcache_props
(
    input logic                  clk,
    input logic                  rst_n,
    input logic                  rd_i,
    input dcache_mem_pkg::strb_t strb_i,
    input logic                  accept_i,
    input logic                  ack_i,
    input logic                  mem_rd_i,
    input logic                  mem_wr_i,
    input dcache_mem_pkg::addr_t mem_addr_i,
    input dcache_mem_pkg::word_t mem_wdata_i,
    input logic                  mem_accept_i
);
    // Request taken and not yet answered
    logic pending_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pending_q <= 1'b0;
        else if (accept_i && (rd_i || (|strb_i)))
            pending_q <= 1'b1;
        else if (ack_i)
            pending_q <= 1'b0;
    end

    ack_follows_accept: assert property (@(posedge clk) disable iff (!rst_n)
        ack_i |-> pending_q)
        else $error("ack without an accepted request");

    // Memory requests stay put until the memory takes them
    rd_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_rd_i && !mem_accept_i) |=> (mem_rd_i && $stable(mem_addr_i)))
        else $error("refill read dropped or changed before accept");

    wr_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_wr_i && !mem_accept_i) |=>
        (mem_wr_i && $stable(mem_addr_i) && $stable(mem_wdata_i)))
        else $error("eviction write dropped or changed before accept");

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_rd_i && mem_wr_i))
        else $error("memory read and write requested together");

endmodule

/* verification/dcache_stim.txt */
// Columns: op addr wdata strb expected, all hex
// op 0 read, 1 read hit, 2 write, 3 write hit, 4 held read, 5 memory word, 6 victim line
0 00000104 00000000 0 a5a50104
1 00000108 00000000 0 a5a50108
3 00000104 11223344 3 00000000
4 00000104 00000000 0 a5a53344
2 00001024 deadbeef f 00000000
2 00002028 cafef00d f 00000000
0 0000302c 00000000 0 a5a5302c
6 00001020 00000000 0 00000000
5 00001024 00000000 0 deadbeef
5 00001020 00000000 0 a5a51020
0 00001024 00000000 0 deadbeef
6 00002020 00000000 0 00000000
5 00002028 00000000 0 cafef00d
5 00002020 00000000 0 a5a52020
2 00004054 00ab0000 4 00000000
1 00004054 00000000 0 a5ab4054
3 00004058 77000000 8 00000000
1 00004058 00000000 0 77a54058
1 00000108 00000000 0 a5a50108

/* verification/dcache_tb.sv */
// ----------------------------------------
// Data cache testbench
// Line burst memory model, requests read
// from a file, result checks and timeout
// ----------------------------------------
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb;
    import dcache_mem_pkg::*;

    localparam int STIM_MAX  = 64;
    localparam int STIM_COLS = 5;

    // Entry kinds of the stimulus file
    localparam logic [31:0] OP_RD        = 32'h0;
    localparam logic [31:0] OP_RD_HIT    = 32'h1;
    localparam logic [31:0] OP_WR        = 32'h2;
    localparam logic [31:0] OP_WR_HIT    = 32'h3;
    localparam logic [31:0] OP_RD_HOLD   = 32'h4;
    localparam logic [31:0] OP_MEM_CHK   = 32'h5;
    localparam logic [31:0] OP_EVICT_CHK = 32'h6;

    logic  clk;
    logic  rst_n;
    addr_t addr;
    word_t wdata;
    logic  rd;
    strb_t strb;
    logic  accept;
    logic  ack;
    word_t rdata;
    logic  mem_rd;
    logic  mem_wr;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_accept;
    logic  mem_ack;
    word_t mem_rdata;

    logic [31:0] stim_words [STIM_MAX*STIM_COLS];
    int          stim_count;
    int          cycle_count;
    int          cycle_limit = STIM_MAX * 80 + 200;
    integer      seed = 32'h7605ca07;
    word_t       mem_model [addr_t];
    int          mem_req_count = 0;
    int          refill_count = 0;
    addr_t       evict_base = '0;

    dcache_top i_dut
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .rd_i         (rd),
        .strb_i       (strb),
        .accept_o     (accept),
        .ack_o        (ack),
        .rdata_o      (rdata),
        .mem_rd_o     (mem_rd),
        .mem_wr_o     (mem_wr),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_accept_i (mem_accept),
        .mem_ack_i    (mem_ack),
        .mem_rdata_i  (mem_rdata)
    );

    bind dcache_ctrl dcache_props u_props
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_i         (rd_i),
        .strb_i       (strb_i),
        .accept_i     (accept_o),
        .ack_i        (ack_o),
        .mem_rd_i     (mem_rd_o),
        .mem_wr_i     (mem_wr_o),
        .mem_addr_i   (mem_addr_o),
        .mem_wdata_i  (mem_wdata_o),
        .mem_accept_i (mem_accept_i)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic report_failure(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            report_failure($sformatf("MISMATCH %s expected %08h actual %08h",
                                     name, expected, actual));
    endtask

    // Untouched words hold a pattern of their own address
    function automatic word_t fetch_word(input addr_t a);
        if (mem_model.exists(a))
            return mem_model[a];
        return a ^ 32'hA5A5_0000;
    endfunction

    task automatic random_wait();
        int n;
        n = $unsigned($random(seed)) % 3;
        repeat (n) @(posedge clk);
    endtask

    task automatic drive_request(input logic is_read, input addr_t a, input word_t d,
                                 input strb_t s);
        addr  <= a;
        wdata <= d;
        rd    <= is_read;
        strb  <= is_read ? '0 : s;
    endtask

    task automatic drive_idle();
        rd   <= 1'b0;
        strb <= '0;
    endtask

    // ----------------------------------------
    // Memory model
    // ----------------------------------------
    initial
    begin
        addr_t base;
        addr_t waddr;
        word_t wseen;
        mem_accept = 1'b0;
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        forever
        begin
            @(negedge clk);
            if (mem_rd)
            begin
                mem_req_count++;
                refill_count++;
                random_wait();
                @(posedge clk);
                mem_accept <= 1'b1;
                @(negedge clk);
                base = mem_addr;
                @(posedge clk);
                mem_accept <= 1'b0;
                check_value("refill address alignment", 32'h0, {28'h0, base[3:0]});
                for (int i = 0; i < `DC_LINE_WORDS; i++)
                begin
                    random_wait();
                    @(posedge clk);
                    mem_ack   <= 1'b1;
                    mem_rdata <= fetch_word(base + addr_t'(4 * i));
                    @(posedge clk);
                    mem_ack <= 1'b0;
                end
            end
            else if (mem_wr)
            begin
                mem_req_count++;
                for (int i = 0; i < `DC_LINE_WORDS; i++)
                begin
                    random_wait();
                    @(posedge clk);
                    mem_accept <= 1'b1;
                    @(negedge clk);
                    check_value("eviction write held", 32'h1, {31'h0, mem_wr});
                    waddr = mem_addr;
                    wseen = mem_wdata;
                    @(posedge clk);
                    mem_accept <= 1'b0;
                    if (i == 0)
                    begin
                        check_value("eviction address alignment", 32'h0, {28'h0, waddr[3:0]});
                        evict_base = waddr;
                    end
                    else
                        check_value("eviction address order", evict_base + addr_t'(4 * i), waddr);
                    mem_model[waddr] = wseen;
                end
                // One ack closes the burst
                random_wait();
                @(posedge clk);
                mem_ack <= 1'b1;
                @(posedge clk);
                mem_ack <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Requests
    // ----------------------------------------
    task automatic run_entry(input int idx);
        logic [31:0] op;
        addr_t       a;
        word_t       d;
        strb_t       s;
        word_t       expected;
        logic        is_read;
        int          wait_cycles;
        int          count_before;
        int          refills_before;
        string       name;
        op       = stim_words[idx*STIM_COLS];
        a        = stim_words[idx*STIM_COLS+1];
        d        = stim_words[idx*STIM_COLS+2];
        s        = strb_t'(stim_words[idx*STIM_COLS+3]);
        expected = stim_words[idx*STIM_COLS+4];
        is_read  = (op == OP_RD) || (op == OP_RD_HIT) || (op == OP_RD_HOLD);
        name     = $sformatf("entry %0d addr %08h", idx, a);
        if (op == OP_MEM_CHK)
            check_value({name, " memory word"}, expected, fetch_word(a));
        else if (op == OP_EVICT_CHK)
            check_value({name, " victim line"}, a, evict_base);
        else if (op > OP_RD_HOLD)
            report_failure($sformatf("stimulus entry %0d has unknown op %0h", idx, op));
        else
        begin
            count_before   = mem_req_count;
            refills_before = refill_count;
            if (op == OP_RD_HOLD)
            begin
                // Already presented in the ack cycle of the buffered write
                check_value({name, " read after write hold"}, 32'h0, {31'h0, accept});
                @(negedge clk);
            end
            else
            begin
                @(posedge clk);
                drive_request(is_read, a, d, s);
                @(negedge clk);
            end
            while (!accept)
                @(negedge clk);
            @(posedge clk);
            if (idx + 1 < stim_count && stim_words[(idx+1)*STIM_COLS] == OP_RD_HOLD)
                drive_request(1'b1, stim_words[(idx+1)*STIM_COLS+1], '0, '0);
            else
                drive_idle();
            wait_cycles = 0;
            @(negedge clk);
            while (!ack)
            begin
                wait_cycles++;
                @(negedge clk);
            end
            if (is_read)
                check_value({name, " read data"}, expected, rdata);
            if (op == OP_RD_HIT || op == OP_WR_HIT)
            begin
                check_value({name, " hit latency"}, 32'h0, wait_cycles);
                check_value({name, " memory requests"}, count_before, mem_req_count);
            end
            // A miss is served by exactly one line refill
            if (op == OP_RD || op == OP_WR)
                check_value({name, " refill count"}, refills_before + 1, refill_count);
        end
    endtask

    initial
    begin
        int low_cycles;
        rst_n = 1'b0;
        addr  = '0;
        wdata = '0;
        rd    = 1'b0;
        strb  = '0;
        for (int k = 0; k < STIM_MAX*STIM_COLS; k++)
            stim_words[k] = '1;
        $readmemh("verification/dcache_stim.txt", stim_words);
        stim_count = 0;
        while (stim_count < STIM_MAX && stim_words[stim_count*STIM_COLS] != '1)
            stim_count++;
        if (stim_count == 0)
            report_failure("the stimulus file holds no entries");
        cycle_limit = stim_count * 80 + 200;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Power-on sweep over all sets
        low_cycles = 0;
        @(negedge clk);
        while (!accept)
        begin
            low_cycles++;
            if (mem_rd || mem_wr)
                report_failure("the memory port was used during the power-on sweep");
            @(negedge clk);
        end
        if (low_cycles < (1 << `DC_SET_W))
            report_failure($sformatf("requests were accepted after only %0d sweep cycles",
                                     low_cycles));

        for (int idx = 0; idx < stim_count; idx++)
            run_entry(idx);

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Run limit from the number of entries
    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        report_failure($sformatf("the run did not finish within %0d cycles", cycle_limit));
    end

endmodule
